/* verilog/apu_pkg.sv */
`default_nettype none

package apu_pkg;

  // Plain widths
  typedef logic signed [23:0] sample_t;
  typedef logic [3:0]         level_t;
  typedef logic [10:0]        freq_t;
  typedef logic [2:0]         master_vol_t;
  typedef logic [7:0]         reg_addr_t;
  typedef logic [7:0]         reg_data_t;

  // Internal counters and accumulators
  typedef logic [11:0]        square_timer_t;
  typedef logic [21:0]        noise_div_t;
  typedef logic [14:0]        lfsr_t;
  typedef logic signed [28:0] mix_acc_t;

  // Register map, low byte of the console address
  localparam reg_addr_t ADDR_NR11 = 8'h11;
  localparam reg_addr_t ADDR_NR12 = 8'h12;
  localparam reg_addr_t ADDR_NR13 = 8'h13;
  localparam reg_addr_t ADDR_NR14 = 8'h14;
  localparam reg_addr_t ADDR_NR42 = 8'h21;
  localparam reg_addr_t ADDR_NR43 = 8'h22;
  localparam reg_addr_t ADDR_NR44 = 8'h23;
  localparam reg_addr_t ADDR_NR50 = 8'h24;
  localparam reg_addr_t ADDR_NR51 = 8'h25;
  localparam reg_addr_t ADDR_NR52 = 8'h26;

  localparam int            SAMPLE_SHIFT = 16;
  localparam square_timer_t FREQ_LIMIT   = 12'd2048;
  localparam lfsr_t         LFSR_SEED    = 15'h7fff;

  // Duty patterns indexed by the NR11 code, bit index is the step
  localparam logic [3:0][7:0] DUTY_TABLE = {
    8'b1111_1100, 8'b1111_0000, 8'b1100_0000, 8'b1000_0000
  };

  // Noise divisor for code 0, and per code step otherwise
  localparam noise_div_t NOISE_DIV_ZERO = 22'd8;
  localparam noise_div_t NOISE_DIV_STEP = 22'd16;

  // NR51 bit positions for the two channels kept
  localparam int ROUTE_SQ_RIGHT    = 0;
  localparam int ROUTE_NOISE_RIGHT = 3;
  localparam int ROUTE_SQ_LEFT     = 4;
  localparam int ROUTE_NOISE_LEFT  = 7;

  localparam int MIX_SHIFT = 3;

  typedef struct packed {
    logic [1:0] duty;
    level_t     volume;
    freq_t      freq;
    logic       enable;
  } square_ctrl_t;

  typedef struct packed {
    level_t     volume;
    logic [3:0] shift;
    logic       short_mode;
    logic [2:0] div_code;
    logic       enable;
  } noise_ctrl_t;

  typedef struct packed {
    logic [7:0]  route;
    master_vol_t vol_left;
    master_vol_t vol_right;
    logic        power;
  } mix_ctrl_t;

endpackage

`default_nettype wire

/* verilog/apu_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_regs (
  input  wire                        system_clock,
  input  wire                        arst_n,
  input  wire                        reg_wr,
  input  wire apu_pkg::reg_addr_t    reg_addr,
  input  wire apu_pkg::reg_data_t    reg_data,
  output apu_pkg::square_ctrl_t      sq_ctrl,
  output apu_pkg::noise_ctrl_t       noise_ctrl,
  output apu_pkg::mix_ctrl_t         mix_ctrl,
  output logic                       sq_trigger,
  output logic                       noise_trigger
);

  logic wr_power_reg;
  logic wr_live;

  // NR52 always reaches the power bit, the rest only while powered
  assign wr_power_reg = reg_wr && (reg_addr == apu_pkg::ADDR_NR52);
  assign wr_live      = reg_wr && mix_ctrl.power && !wr_power_reg;

  always_ff @(posedge system_clock or negedge arst_n) begin
    if (!arst_n) begin
      sq_ctrl       <= '0;
      noise_ctrl    <= '0;
      mix_ctrl      <= '0;
      sq_trigger    <= 1'b0;
      noise_trigger <= 1'b0;
    end else begin
      sq_trigger    <= 1'b0;
      noise_trigger <= 1'b0;

      if (wr_power_reg) begin
        if (!reg_data[7]) begin
          // Power off wipes every register and both enables
          sq_ctrl    <= '0;
          noise_ctrl <= '0;
          mix_ctrl   <= '0;
        end else begin
          mix_ctrl.power <= 1'b1;
        end
      end

      if (wr_live) begin
        case (reg_addr)
          apu_pkg::ADDR_NR11: sq_ctrl.duty <= reg_data[7:6];
          apu_pkg::ADDR_NR12: sq_ctrl.volume <= reg_data[7:4];
          apu_pkg::ADDR_NR13: sq_ctrl.freq[7:0] <= reg_data;
          apu_pkg::ADDR_NR14: begin
            sq_ctrl.freq[10:8] <= reg_data[2:0];
            if (reg_data[7]) begin
              sq_ctrl.enable <= 1'b1;
              sq_trigger     <= 1'b1;
            end
          end
          apu_pkg::ADDR_NR42: noise_ctrl.volume <= reg_data[7:4];
          apu_pkg::ADDR_NR43: begin
            noise_ctrl.shift      <= reg_data[7:4];
            noise_ctrl.short_mode <= reg_data[3];
            noise_ctrl.div_code   <= reg_data[2:0];
          end
          apu_pkg::ADDR_NR44: begin
            if (reg_data[7]) begin
              noise_ctrl.enable <= 1'b1;
              noise_trigger     <= 1'b1;
            end
          end
          apu_pkg::ADDR_NR50: begin
            // Bit 7 is the cartridge input enable, not modelled
            mix_ctrl.vol_left  <= reg_data[6:4];
            mix_ctrl.vol_right <= reg_data[2:0];
          end
          apu_pkg::ADDR_NR51: mix_ctrl.route <= reg_data;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/square_channel.sv */
`timescale 1ns/100ps
`default_nettype none

module square_channel (
  input  wire                           system_clock,
  input  wire                           arst_n,
  input  wire apu_pkg::square_ctrl_t    ctrl,
  input  wire                           trigger,
  output apu_pkg::sample_t              sample
);

  apu_pkg::square_timer_t timer;
  apu_pkg::square_timer_t timer_next;
  apu_pkg::square_timer_t period;
  logic [2:0]             step;
  logic [2:0]             step_next;
  logic [7:0]             duty_bits;
  logic                   level_high;
  apu_pkg::sample_t       magnitude;

  // Timer reload value, one duty step per period
  assign period = apu_pkg::FREQ_LIMIT - apu_pkg::square_timer_t'(ctrl.freq);

  always_comb begin
    timer_next = timer;
    step_next  = step;
    if (trigger) begin
      timer_next = period;
      step_next  = '0;
    end else if (ctrl.enable) begin
      if (timer <= apu_pkg::square_timer_t'(1)) begin
        timer_next = period;
        step_next  = step + 3'd1;
      end else begin
        timer_next = timer - apu_pkg::square_timer_t'(1);
      end
    end
  end

  // Sample is taken from the next step so it lines up with the state
  assign duty_bits  = apu_pkg::DUTY_TABLE[ctrl.duty];
  assign level_high = duty_bits[step_next];
  assign magnitude  = apu_pkg::sample_t'(ctrl.volume) << apu_pkg::SAMPLE_SHIFT;

  always_ff @(posedge system_clock or negedge arst_n) begin
    if (!arst_n) begin
      timer <= '0;
      step  <= '0;
    end else begin
      timer <= timer_next;
      step  <= step_next;
    end
  end

  always_ff @(posedge system_clock or negedge arst_n) begin
    if (!arst_n) begin
      sample <= '0;
    end else if (!ctrl.enable) begin
      sample <= '0;
    end else if (level_high) begin
      sample <= magnitude;
    end else begin
      sample <= -magnitude;
    end
  end

endmodule

`default_nettype wire

/* verilog/noise_channel.sv */
`timescale 1ns/100ps
`default_nettype none

module noise_channel (
  input  wire                          system_clock,
  input  wire                          arst_n,
  input  wire apu_pkg::noise_ctrl_t    ctrl,
  input  wire                          trigger,
  output apu_pkg::sample_t             sample
);

  apu_pkg::noise_div_t divisor;
  apu_pkg::noise_div_t period;
  apu_pkg::noise_div_t count;
  apu_pkg::noise_div_t count_next;
  apu_pkg::lfsr_t      lfsr;
  apu_pkg::lfsr_t      lfsr_next;
  apu_pkg::lfsr_t      lfsr_shifted;
  logic                feedback;
  apu_pkg::sample_t    magnitude;

  // Code 0 divides by 8, any other code by 16 times the code
  assign divisor = (ctrl.div_code == 3'd0) ? apu_pkg::NOISE_DIV_ZERO :
                   apu_pkg::noise_div_t'(ctrl.div_code) * apu_pkg::NOISE_DIV_STEP;
  assign period  = divisor << ctrl.shift;

  always_comb begin
    feedback     = lfsr[0] ^ lfsr[1];
    lfsr_shifted = {feedback, lfsr[14:1]};
    if (ctrl.short_mode) begin
      // 7-bit sequence
      lfsr_shifted[6] = feedback;
    end
  end

  always_comb begin
    count_next = count;
    lfsr_next  = lfsr;
    if (trigger) begin
      count_next = period;
      lfsr_next  = apu_pkg::LFSR_SEED;
    end else if (ctrl.enable) begin
      if (count <= apu_pkg::noise_div_t'(1)) begin
        count_next = period;
        lfsr_next  = lfsr_shifted;
      end else begin
        count_next = count - apu_pkg::noise_div_t'(1);
      end
    end
  end

  assign magnitude = apu_pkg::sample_t'(ctrl.volume) << apu_pkg::SAMPLE_SHIFT;

  always_ff @(posedge system_clock or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
      lfsr  <= '0;
    end else begin
      count <= count_next;
      lfsr  <= lfsr_next;
    end
  end

  always_ff @(posedge system_clock or negedge arst_n) begin
    if (!arst_n) begin
      sample <= '0;
    end else if (!ctrl.enable) begin
      sample <= '0;
    end else if (lfsr_next[0]) begin
      sample <= -magnitude;
    end else begin
      sample <= magnitude;
    end
  end

endmodule

`default_nettype wire

/* verilog/stereo_mixer.sv */
`timescale 1ns/100ps
`default_nettype none

module stereo_mixer (
  input  wire                        system_clock,
  input  wire                        arst_n,
  input  wire apu_pkg::mix_ctrl_t    mix_ctrl,
  input  wire apu_pkg::sample_t      sq_sample,
  input  wire apu_pkg::sample_t      noise_sample,
  output apu_pkg::sample_t           output_wave_left,
  output apu_pkg::sample_t           output_wave_right
);

  apu_pkg::sample_t mix_left;
  apu_pkg::sample_t mix_right;

  // Routed sum of one side, scaled by master volume plus one
  function automatic apu_pkg::sample_t mix_side(
    input apu_pkg::sample_t    sq,
    input apu_pkg::sample_t    noise,
    input logic                use_sq,
    input logic                use_noise,
    input apu_pkg::master_vol_t vol
  );
    apu_pkg::mix_acc_t sum;
    apu_pkg::mix_acc_t scale;
    apu_pkg::mix_acc_t product;
    sum = '0;
    if (use_sq) begin
      sum = sum + apu_pkg::mix_acc_t'(sq);
    end
    if (use_noise) begin
      sum = sum + apu_pkg::mix_acc_t'(noise);
    end
    scale   = apu_pkg::mix_acc_t'(vol) + apu_pkg::mix_acc_t'(1);
    // Wide accumulator keeps the full product before the shift
    product = sum * scale;
    return apu_pkg::sample_t'(product >>> apu_pkg::MIX_SHIFT);
  endfunction

  always_comb begin
    mix_left  = mix_side(sq_sample, noise_sample,
                         mix_ctrl.route[apu_pkg::ROUTE_SQ_LEFT],
                         mix_ctrl.route[apu_pkg::ROUTE_NOISE_LEFT],
                         mix_ctrl.vol_left);
    mix_right = mix_side(sq_sample, noise_sample,
                         mix_ctrl.route[apu_pkg::ROUTE_SQ_RIGHT],
                         mix_ctrl.route[apu_pkg::ROUTE_NOISE_RIGHT],
                         mix_ctrl.vol_right);
  end

  always_ff @(posedge system_clock or negedge arst_n) begin
    if (!arst_n) begin
      output_wave_left  <= '0;
      output_wave_right <= '0;
    end else if (!mix_ctrl.power) begin
      output_wave_left  <= '0;
      output_wave_right <= '0;
    end else begin
      output_wave_left  <= mix_left;
      output_wave_right <= mix_right;
    end
  end

endmodule

`default_nettype wire

/* verilog/apu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_top (
  input  wire                        system_clock,
  input  wire                        arst_n,
  input  wire                        reg_wr,
  input  wire apu_pkg::reg_addr_t    reg_addr,
  input  wire apu_pkg::reg_data_t    reg_data,
  output apu_pkg::sample_t           output_wave_left,
  output apu_pkg::sample_t           output_wave_right
);

  apu_pkg::square_ctrl_t sq_ctrl;
  apu_pkg::noise_ctrl_t   noise_ctrl;
  apu_pkg::mix_ctrl_t     mix_ctrl;
  logic                   sq_trigger;
  logic                   noise_trigger;
  apu_pkg::sample_t       sq_sample;
  apu_pkg::sample_t       noise_sample;

  apu_regs u_regs (
    .system_clock  (system_clock),
    .arst_n        (arst_n),
    .reg_wr        (reg_wr),
    .reg_addr      (reg_addr),
    .reg_data      (reg_data),
    .sq_ctrl       (sq_ctrl),
    .noise_ctrl    (noise_ctrl),
    .mix_ctrl      (mix_ctrl),
    .sq_trigger    (sq_trigger),
    .noise_trigger (noise_trigger)
  );

  // Channel 1
  square_channel u_square (
    .system_clock (system_clock),
    .arst_n       (arst_n),
    .ctrl         (sq_ctrl),
    .trigger      (sq_trigger),
    .sample       (sq_sample)
  );

  // Channel 4
  noise_channel u_noise (
    .system_clock (system_clock),
    .arst_n       (arst_n),
    .ctrl         (noise_ctrl),
    .trigger      (noise_trigger),
    .sample       (noise_sample)
  );

  stereo_mixer u_mixer (
    .system_clock      (system_clock),
    .arst_n            (arst_n),
    .mix_ctrl          (mix_ctrl),
    .sq_sample         (sq_sample),
    .noise_sample      (noise_sample),
    .output_wave_left  (output_wave_left),
    .output_wave_right (output_wave_right)
  );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic system_clock,
  output logic arst_n
);

  // 4 ns period
  initial begin
    system_clock = 1'b0;
    forever #2 system_clock = ~system_clock;
  end

  // Released on a falling edge, clear of the sampling edge
  initial begin
    arst_n = 1'b0;
    repeat (16) @(posedge system_clock);
    @(negedge system_clock);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/apu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_tb;

  // Planned cycles per test group, writes cost two cycles each
  localparam int LEN_SETUP  = 80;
  localparam int LEN_DUTY   = 2080 + 4 * 3860;
  localparam int LEN_NOISE  = 1060;
  localparam int LEN_MIX    = 1040 + 120;
  localparam int LIMIT      = 3 * (LEN_SETUP + LEN_DUTY + LEN_NOISE + LEN_MIX) / 2;

  wire                   system_clock;
  wire                   arst_n;
  logic                  reg_wr;
  apu_pkg::reg_addr_t    reg_addr;
  apu_pkg::reg_data_t    reg_data;
  apu_pkg::sample_t      output_wave_left;
  apu_pkg::sample_t      output_wave_right;

  // Reference model, register stage then channel stage
  apu_pkg::square_ctrl_t m_sq;
  apu_pkg::noise_ctrl_t  m_noise;
  apu_pkg::mix_ctrl_t    m_mix;
  logic                  m_sq_trig;
  int                    m_phase;
  int                    m_step;
  int                    c_sq;
  int                    c_noise;
  // Index 0 adds the noise level, index 1 subtracts it
  int                    exp_left [2];
  int                    exp_right [2];
  int                    errors = 0;
  int                    checks = 0;
  int                    cycles = 0;

  tb_clock_gen u_clock (
    .system_clock (system_clock),
    .arst_n       (arst_n)
  );

  apu_top DUT (
    .system_clock      (system_clock),
    .arst_n            (arst_n),
    .reg_wr            (reg_wr),
    .reg_addr          (reg_addr),
    .reg_data          (reg_data),
    .output_wave_left  (output_wave_left),
    .output_wave_right (output_wave_right)
  );

  // High steps sit at the end of the 8-step pattern
  function automatic int duty_ones(input logic [1:0] duty);
    case (duty)
      2'd0: return 1;
      2'd1: return 2;
      2'd2: return 4;
      default: return 6;
    endcase
  endfunction

  function automatic int scale_side(input int sum, input int vol);
    return (sum * (vol + 1)) >>> 3;
  endfunction

  always @(posedge system_clock or negedge arst_n) begin : ref_model
    int per;
    int sq_l;
    int sq_r;
    int n_l;
    int n_r;
    if (!arst_n) begin
      m_sq         = '0;
      m_noise      = '0;
      m_mix        = '0;
      m_sq_trig    = 1'b0;
      m_phase      = 0;
      m_step       = 0;
      c_sq         = 0;
      c_noise      = 0;
      exp_left[0]  = 0;
      exp_left[1]  = 0;
      exp_right[0] = 0;
      exp_right[1] = 0;
    end else begin
      sq_l = m_mix.route[4] ? c_sq : 0;
      n_l  = m_mix.route[7] ? c_noise : 0;
      sq_r = m_mix.route[0] ? c_sq : 0;
      n_r  = m_mix.route[3] ? c_noise : 0;
      exp_left[0]  = m_mix.power ? scale_side(sq_l + n_l, m_mix.vol_left) : 0;
      exp_left[1]  = m_mix.power ? scale_side(sq_l - n_l, m_mix.vol_left) : 0;
      exp_right[0] = m_mix.power ? scale_side(sq_r + n_r, m_mix.vol_right) : 0;
      exp_right[1] = m_mix.power ? scale_side(sq_r - n_r, m_mix.vol_right) : 0;
      per = 2048 - int'(m_sq.freq);
      if (m_sq_trig) begin
        m_phase = 0;
        m_step  = 0;
      end else if (m_sq.enable) begin
        m_phase = m_phase + 1;
        if (m_phase >= per) begin
          m_phase = 0;
          m_step  = (m_step + 1) % 8;
        end
      end
      if (!m_sq.enable) begin
        c_sq = 0;
      end else begin
        c_sq = (m_step >= 8 - duty_ones(m_sq.duty)) ? (int'(m_sq.volume) << 16) :
               -(int'(m_sq.volume) << 16);
      end
      c_noise   = m_noise.enable ? (int'(m_noise.volume) << 16) : 0;
      m_sq_trig = 1'b0;
      if (reg_wr && reg_addr == apu_pkg::ADDR_NR52) begin
        if (reg_data[7]) begin
          m_mix.power = 1'b1;
        end else begin
          m_sq    = '0;
          m_noise = '0;
          m_mix   = '0;
        end
      end else if (reg_wr && m_mix.power) begin
        case (reg_addr)
          apu_pkg::ADDR_NR11: m_sq.duty = reg_data[7:6];
          apu_pkg::ADDR_NR12: m_sq.volume = reg_data[7:4];
          apu_pkg::ADDR_NR13: m_sq.freq[7:0] = reg_data;
          apu_pkg::ADDR_NR14: begin
            m_sq.freq[10:8] = reg_data[2:0];
            m_sq.enable     = m_sq.enable | reg_data[7];
            m_sq_trig       = reg_data[7];
          end
          apu_pkg::ADDR_NR42: m_noise.volume = reg_data[7:4];
          apu_pkg::ADDR_NR44: m_noise.enable = m_noise.enable | reg_data[7];
          apu_pkg::ADDR_NR50: begin
            m_mix.vol_left  = reg_data[6:4];
            m_mix.vol_right = reg_data[2:0];
          end
          apu_pkg::ADDR_NR51: m_mix.route = reg_data;
          default: ;
        endcase
      end
    end
  end

  // Outputs are stable on the falling edge
  always @(negedge system_clock) begin
    if (arst_n) begin
      checks++;
      assert (output_wave_left == exp_left[0] || output_wave_left == exp_left[1]) else begin
        errors++;
        $display("ERR %0t: left output %0d, expected %0d or %0d", $time,
                 output_wave_left, exp_left[0], exp_left[1]);
      end
      assert (output_wave_right == exp_right[0] || output_wave_right == exp_right[1]) else begin
        errors++;
        $display("ERR %0t: right output %0d, expected %0d or %0d", $time,
                 output_wave_right, exp_right[0], exp_right[1]);
      end
    end
  end

  always @(posedge system_clock) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic bus_write(input apu_pkg::reg_addr_t addr, input apu_pkg::reg_data_t data);
    @(negedge system_clock);
    reg_wr   = 1'b1;
    reg_addr = addr;
    reg_data = data;
    @(negedge system_clock);
    reg_wr   = 1'b0;
  endtask

  task automatic compare_value(input string what, input int got, input int expected);
    checks++;
    assert (got == expected) else begin
      errors++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // Power cycle, then master volumes and routing
  task automatic restart_mix(input apu_pkg::master_vol_t vl, input apu_pkg::master_vol_t vr,
                             input apu_pkg::reg_data_t route);
    bus_write(apu_pkg::ADDR_NR52, 8'h00);
    bus_write(apu_pkg::ADDR_NR52, 8'h80);
    bus_write(apu_pkg::ADDR_NR50, {1'b0, vl, 1'b0, vr});
    bus_write(apu_pkg::ADDR_NR51, route);
  endtask

  task automatic start_square(input logic [1:0] duty, input apu_pkg::level_t vol, input int per);
    apu_pkg::freq_t freq;
    freq = apu_pkg::freq_t'(2048 - per);
    bus_write(apu_pkg::ADDR_NR11, {duty, 6'd0});
    bus_write(apu_pkg::ADDR_NR12, {vol, 4'd0});
    bus_write(apu_pkg::ADDR_NR13, freq[7:0]);
    bus_write(apu_pkg::ADDR_NR14, {5'b10000, freq[10:8]});
  endtask

  initial begin : stimulus
    int seed;
    int per;
    int count;
    int pos_count;
    int neg_count;
    apu_pkg::master_vol_t vl;
    apu_pkg::master_vol_t vr;
    apu_pkg::level_t vol;
    logic [1:0] duty;
    reg_wr   = 1'b0;
    reg_addr = '0;
    reg_data = '0;
    seed     = $urandom(12013);
    wait (arst_n === 1'b1);

    // Writes before power on are ignored
    bus_write(apu_pkg::ADDR_NR51, 8'hff);
    bus_write(apu_pkg::ADDR_NR50, 8'h77);
    bus_write(apu_pkg::ADDR_NR12, 8'hf0);
    bus_write(apu_pkg::ADDR_NR14, 8'h87);
    repeat (20) @(negedge system_clock);
    compare_value("left before power on", output_wave_left, 0);
    compare_value("right before power on", output_wave_right, 0);
    // Nothing was latched, so power alone stays silent
    bus_write(apu_pkg::ADDR_NR52, 8'h80);
    repeat (20) @(negedge system_clock);
    compare_value("left after locked writes", output_wave_left, 0);
    compare_value("right after locked writes", output_wave_right, 0);

    // Square on the left only, high cycles over one full pattern
    vl   = $urandom_range(7, 0);
    vr   = $urandom_range(7, 0);
    vol  = $urandom_range(15, 1);
    duty = $urandom_range(3, 0);
    per  = $urandom_range(256, 4);
    restart_mix(vl, vr, 8'h10);
    start_square(duty, vol, per);
    repeat (3) @(negedge system_clock);
    count = 0;
    repeat (8 * per) begin
      @(negedge system_clock);
      if (output_wave_left > 0) count++;
      compare_value("right with left-only route", output_wave_right, 0);
      compare_value("left level magnitude",
                    (output_wave_left < 0) ? -output_wave_left : output_wave_left,
                    ((int'(vol) << 16) * (int'(vl) + 1)) >>> 3);
    end
    compare_value("high cycles per pattern", count, duty_ones(duty) * per);

    // First high level after write, channel and mixer edges plus the low steps
    for (int d = 0; d < 4; d++) begin
      per = $urandom_range(256, 4);
      vol = $urandom_range(15, 1);
      restart_mix(3'd7, 3'd0, 8'h10);
      start_square(d[1:0], vol, per);
      count = 0;
      while (output_wave_left <= 0 && count < 8 * per + 8) begin
        @(negedge system_clock);
        count++;
      end
      compare_value("cycles to first high level", count, 2 + (8 - duty_ones(d[1:0])) * per);
      repeat (8 * per) @(negedge system_clock);
    end

    // Noise alone on the right, short sequence of 127 states
    vol = $urandom_range(15, 1);
    vr  = $urandom_range(7, 0);
    restart_mix(3'd0, vr, 8'h08);
    bus_write(apu_pkg::ADDR_NR42, {vol, 4'd0});
    bus_write(apu_pkg::ADDR_NR43, 8'h08);
    bus_write(apu_pkg::ADDR_NR44, 8'h80);
    pos_count = 0;
    neg_count = 0;
    repeat (127 * 8 + 16) begin
      @(negedge system_clock);
      if (output_wave_right > 0) pos_count++;
      if (output_wave_right < 0) neg_count++;
    end
    compare_value("noise positive level seen", int'(pos_count > 0), 1);
    compare_value("noise negative level seen", int'(neg_count > 0), 1);

    // Both channels on both sides, then only the left volume moves
    vl  = $urandom_range(7, 0);
    vr  = $urandom_range(7, 0);
    vol = $urandom_range(15, 1);
    restart_mix(vl, vr, 8'h99);
    start_square($urandom_range(3, 0), vol, $urandom_range(256, 4));
    vol = $urandom_range(15, 1);
    bus_write(apu_pkg::ADDR_NR42, {vol, 4'd0});
    bus_write(apu_pkg::ADDR_NR43, 8'h19);
    bus_write(apu_pkg::ADDR_NR44, 8'h80);
    repeat (500) @(negedge system_clock);
    bus_write(apu_pkg::ADDR_NR50, {1'b0, vl + 3'd3, 1'b0, vr});
    repeat (500) @(negedge system_clock);

    // Power off silences at once, channels stay off until retriggered
    bus_write(apu_pkg::ADDR_NR52, 8'h00);
    count = 0;
    while ((output_wave_left != 0 || output_wave_right != 0) && count < 8) begin
      @(negedge system_clock);
      count++;
    end
    compare_value("power-off latency within 3", int'(count <= 3), 1);
    bus_write(apu_pkg::ADDR_NR52, 8'h80);
    bus_write(apu_pkg::ADDR_NR50, 8'h77);
    bus_write(apu_pkg::ADDR_NR51, 8'hff);
    bus_write(apu_pkg::ADDR_NR12, 8'hf0);
    bus_write(apu_pkg::ADDR_NR42, 8'hf0);
    repeat (50) begin
      @(negedge system_clock);
      compare_value("left before retrigger", output_wave_left, 0);
      compare_value("right before retrigger", output_wave_right, 0);
    end
    bus_write(apu_pkg::ADDR_NR14, 8'h87);
    repeat (40) @(negedge system_clock);
    compare_value("left sounding after retrigger", int'(output_wave_left != 0), 1);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
verilog/apu_pkg.sv
verilog/apu_regs.sv
verilog/square_channel.sv
verilog/noise_channel.sv
verilog/stereo_mixer.sv
verilog/apu_top.sv
verification/tb_clock_gen.sv
verification/apu_tb.sv

/* Bender.yml */
package:
  name: apu_sound

sources:
  - verilog/apu_pkg.sv
  - verilog/apu_regs.sv
  - verilog/square_channel.sv
  - verilog/noise_channel.sv
  - verilog/stereo_mixer.sv
  - verilog/apu_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/apu_tb.sv
